//--- flist.f
hdl/core_pkg.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/core_top.sv
sim/tb_core.sv

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import core_pkg::*; (
    input  word_t   i_op1,
    input  word_t   i_op2,
    input  alu_op_t i_op,
    output word_t   o_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount is the low five bits of the second operand
    assign shamt       = i_op2[4:0];
    assign lt_signed   = $signed(i_op1) < $signed(i_op2);
    assign lt_unsigned = i_op1 < i_op2;

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_op1 + i_op2;
            ALU_SUB:  o_result = i_op1 - i_op2;
            ALU_AND:  o_result = i_op1 & i_op2;
            ALU_OR:   o_result = i_op1 | i_op2;
            ALU_XOR:  o_result = i_op1 ^ i_op2;
            // Compares give 0 or 1
            ALU_SLT:  o_result = {31'd0, lt_signed};
            ALU_SLTU: o_result = {31'd0, lt_unsigned};
            ALU_SLL:  o_result = i_op1 << shamt;
            ALU_SRL:  o_result = i_op1 >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  o_result = word_t'($signed(i_op1) >>> shamt);
            default:  o_result = '0;
        endcase
    end

endmodule

//--- hdl/core_pkg.sv
package core_pkg;

    // Data, address and instruction word
    typedef logic [31:0] word_t;
    // Register number, x0 always reads as zero
    typedef logic [4:0]  reg_addr_t;

    // Integer operations the execute stage can perform
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ALU funct3 codes, shared by the register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // Word access for lw and sw
    localparam logic [2:0] F3_WORD    = 3'b010;

    localparam word_t INST_EBREAK = 32'h0010_0073;
    // addi x0, x0, 0
    localparam word_t NOP_INST    = 32'h0000_0013;

endpackage

//--- hdl/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
    parameter word_t RESET_ADDR = 32'h0000_0000
) (
    input  logic       i_clk,
    input  logic       i_rst,
    // Instruction memory, data follows the address by one edge
    output word_t      o_imem_raddr,
    input  word_t      i_imem_rdata,
    // Data memory, driven from the memory stage, read data lands in writeback
    output word_t      o_dmem_addr,
    output logic       o_dmem_ren,
    output logic       o_dmem_wen,
    output word_t      o_dmem_wdata,
    output logic [3:0] o_dmem_mask,
    input  word_t      i_dmem_rdata,
    // In-order retire port
    output logic       o_retire_valid,
    output logic       o_retire_halt,
    output word_t      o_retire_inst,
    output word_t      o_retire_pc,
    output reg_addr_t  o_retire_rd_waddr,
    output word_t      o_retire_rd_wdata
);

    // Fetch
    word_t     pc_q;
    logic      fetch_valid, halted_q, fetch_stop, fetch_adv;
    // Decode
    word_t     id_pc, id_inst, id_imm, id_rs1_data, id_rs2_data;
    reg_addr_t id_rs1, id_rs2, id_rd;
    logic      id_valid, id_issue, id_uses_rs1, id_uses_rs2, id_reg_write, id_imm_src;
    logic      id_is_lui, id_mem_read, id_mem_write, id_halt, stall;
    alu_op_t   id_alu_op;
    // Execute
    word_t     ex_pc, ex_inst, ex_imm, ex_rs1_data, ex_rs2_data;
    word_t     ex_op_a, ex_op_b, ex_alu_in1, ex_alu_in2, ex_alu_result;
    reg_addr_t ex_rs1, ex_rs2, ex_rd;
    logic      ex_valid, ex_reg_write, ex_imm_src, ex_is_lui, ex_mem_read;
    logic      ex_mem_write, ex_halt;
    alu_op_t   ex_alu_op;
    fwd_sel_t  fwd_a, fwd_b;
    // Memory
    word_t     mem_pc, mem_inst, mem_alu_result, mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_valid, mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;
    // Writeback
    word_t     wb_pc, wb_inst, wb_alu_result, wb_rd_wdata;
    reg_addr_t wb_rd;
    logic      wb_valid, wb_reg_write, wb_mem_read, wb_halt;

    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    rf_data,
        input word_t    mem_data,
        input word_t    wb_data
    );
        case (sel)
            FWD_MEM: fwd_mux = mem_data;
            FWD_WB:  fwd_mux = wb_data;
            default: fwd_mux = rf_data;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    // pc_q is the address of the word now on i_imem_rdata
    // Fetch stops for good once ebreak sits in decode
    assign fetch_stop   = halted_q || (id_valid && id_halt);
    assign fetch_adv    = fetch_valid && !stall && !fetch_stop;
    // Re-reading pc_q keeps the same word on the bus during a stall
    assign o_imem_raddr = fetch_adv ? pc_q + 32'd4 : pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    inst_decoder u_decoder (
        .i_inst(id_inst), .o_rs1(id_rs1), .o_rs2(id_rs2), .o_rd(id_rd),
        .o_uses_rs1(id_uses_rs1), .o_uses_rs2(id_uses_rs2),
        .o_reg_write(id_reg_write), .o_imm_src(id_imm_src), .o_is_lui(id_is_lui),
        .o_mem_read(id_mem_read), .o_mem_write(id_mem_write), .o_halt(id_halt),
        .o_imm(id_imm), .o_alu_op(id_alu_op)
    );

    // Writeback writes here, the bypass covers a same-cycle read
    reg_file u_reg_file (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_rs1_raddr(id_rs1), .i_rs2_raddr(id_rs2),
        .i_rd_waddr(wb_rd), .i_rd_wen(wb_reg_write), .i_rd_wdata(wb_rd_wdata),
        .o_rs1_rdata(id_rs1_data), .o_rs2_rdata(id_rs2_data)
    );

    hazard_unit u_hazard (
        .i_id_rs1(id_rs1), .i_id_rs2(id_rs2),
        .i_id_uses_rs1(id_uses_rs1), .i_id_uses_rs2(id_uses_rs2),
        .i_ex_rd(ex_rd), .i_ex_rs1(ex_rs1), .i_ex_rs2(ex_rs2),
        .i_ex_mem_read(ex_mem_read), .i_ex_valid(ex_valid),
        .i_mem_rd(mem_rd), .i_wb_rd(wb_rd),
        .i_mem_reg_write(mem_reg_write), .i_wb_reg_write(wb_reg_write),
        .o_stall(stall), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
    );

    // A stalled decode slot enters execute as a bubble
    assign id_issue = id_valid && !stall;

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    assign ex_op_a    = fwd_mux(fwd_a, ex_rs1_data, mem_alu_result, wb_rd_wdata);
    assign ex_op_b    = fwd_mux(fwd_b, ex_rs2_data, mem_alu_result, wb_rd_wdata);
    // lui adds its immediate to zero
    assign ex_alu_in1 = ex_is_lui ? '0 : ex_op_a;
    assign ex_alu_in2 = ex_imm_src ? ex_imm : ex_op_b;

    alu u_alu (
        .i_op1(ex_alu_in1), .i_op2(ex_alu_in2), .i_op(ex_alu_op),
        .o_result(ex_alu_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////////////////////

    // Word accesses only, so the low address bits are dropped
    assign o_dmem_addr  = {mem_alu_result[31:2], 2'b00};
    assign o_dmem_ren   = mem_mem_read;
    assign o_dmem_wen   = mem_mem_write;
    assign o_dmem_wdata = mem_store_data;
    assign o_dmem_mask  = 4'b1111;

    // Load data is live on the bus for exactly this cycle
    assign wb_rd_wdata = wb_mem_read ? i_dmem_rdata : wb_alu_result;

    assign o_retire_valid    = wb_valid;
    assign o_retire_halt     = wb_halt;
    assign o_retire_inst     = wb_inst;
    assign o_retire_pc       = wb_pc;
    assign o_retire_rd_waddr = wb_reg_write ? wb_rd : '0;
    assign o_retire_rd_wdata = wb_rd_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////////////

    // Control and valid bits, cleared for bubbles
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q <= RESET_ADDR;
            {fetch_valid, halted_q, id_valid} <= '0;
            {ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_halt} <= '0;
            {mem_valid, mem_reg_write, mem_mem_read, mem_mem_write, mem_halt} <= '0;
            {wb_valid, wb_reg_write, wb_mem_read, wb_halt} <= '0;
        end else begin
            fetch_valid <= !fetch_stop;
            halted_q    <= fetch_stop;
            if (fetch_adv)
                pc_q <= pc_q + 32'd4;
            if (!stall)
                id_valid <= fetch_valid && !fetch_stop;
            ex_valid      <= id_issue;
            ex_reg_write  <= id_issue && id_reg_write;
            ex_mem_read   <= id_issue && id_mem_read;
            ex_mem_write  <= id_issue && id_mem_write;
            ex_halt       <= id_issue && id_halt;
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_halt      <= ex_halt;
            wb_valid      <= mem_valid;
            wb_reg_write  <= mem_reg_write;
            wb_mem_read   <= mem_mem_read;
            wb_halt       <= mem_halt;
        end
    end

    // Payload, bubbles carry the nop encoding
    always_ff @(posedge i_clk) begin
        if (!stall) begin
            id_pc   <= pc_q;
            id_inst <= (fetch_valid && !fetch_stop) ? i_imem_rdata : NOP_INST;
        end
        ex_pc          <= id_pc;
        ex_inst        <= id_issue ? id_inst : NOP_INST;
        ex_imm         <= id_imm;
        ex_rs1_data    <= id_rs1_data;
        ex_rs2_data    <= id_rs2_data;
        ex_rs1         <= id_rs1;
        ex_rs2         <= id_rs2;
        ex_rd          <= id_rd;
        ex_imm_src     <= id_imm_src;
        ex_is_lui      <= id_is_lui;
        ex_alu_op      <= id_alu_op;
        mem_pc         <= ex_pc;
        mem_inst       <= ex_inst;
        mem_rd         <= ex_rd;
        mem_alu_result <= ex_alu_result;
        // Store data is the forwarded rs2 value
        mem_store_data <= ex_op_b;
        wb_pc          <= mem_pc;
        wb_inst        <= mem_inst;
        wb_rd          <= mem_rd;
        wb_alu_result  <= mem_alu_result;
    end

    a_dmem_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_dmem_ren && o_dmem_wen));
    a_dmem_valid: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_dmem_ren || o_dmem_wen) |-> mem_valid);
    a_halt_retires: assert property (@(posedge i_clk) disable iff (i_rst)
        o_retire_halt |-> o_retire_valid);

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import core_pkg::*; (
    // Decode stage sources
    input  reg_addr_t i_id_rs1,
    input  reg_addr_t i_id_rs2,
    input  logic      i_id_uses_rs1,
    input  logic      i_id_uses_rs2,
    // Execute stage
    input  reg_addr_t i_ex_rd,
    input  reg_addr_t i_ex_rs1,
    input  reg_addr_t i_ex_rs2,
    input  logic      i_ex_mem_read,
    input  logic      i_ex_valid,
    // Later stages, write enables already qualified by valid
    input  reg_addr_t i_mem_rd,
    input  reg_addr_t i_wb_rd,
    input  logic      i_mem_reg_write,
    input  logic      i_wb_reg_write,
    output logic      o_stall,
    output fwd_sel_t  o_fwd_a,
    output fwd_sel_t  o_fwd_b
);

    logic rs1_hit;
    logic rs2_hit;

    // Load data only exists in writeback, so a user right behind waits a cycle
    assign rs1_hit = i_id_uses_rs1 && (i_id_rs1 == i_ex_rd);
    assign rs2_hit = i_id_uses_rs2 && (i_id_rs2 == i_ex_rd);
    assign o_stall = i_ex_valid && i_ex_mem_read && (rs1_hit || rs2_hit);

    // Memory stage is younger, so it wins over writeback
    always_comb begin
        o_fwd_a = FWD_RF;
        if (i_mem_reg_write && (i_mem_rd == i_ex_rs1))
            o_fwd_a = FWD_MEM;
        else if (i_wb_reg_write && (i_wb_rd == i_ex_rs1))
            o_fwd_a = FWD_WB;
    end

    always_comb begin
        o_fwd_b = FWD_RF;
        if (i_mem_reg_write && (i_mem_rd == i_ex_rs2))
            o_fwd_b = FWD_MEM;
        else if (i_wb_reg_write && (i_wb_rd == i_ex_rs2))
            o_fwd_b = FWD_WB;
    end

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import core_pkg::*; (
    input  word_t     i_inst,
    output reg_addr_t o_rs1,
    output reg_addr_t o_rs2,
    output reg_addr_t o_rd,
    output logic      o_uses_rs1,
    output logic      o_uses_rs2,
    output logic      o_reg_write,
    output logic      o_imm_src,
    output logic      o_is_lui,
    output logic      o_mem_read,
    output logic      o_mem_write,
    output logic      o_halt,
    output word_t     o_imm,
    output alu_op_t   o_alu_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       write_rd;
    logic       read_rs1;
    logic       read_rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;

    // Operation from funct3, alt picks sub or sra
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_sel = ALU_SLL;
            F3_SLT:     alu_sel = ALU_SLT;
            F3_SLTU:    alu_sel = ALU_SLTU;
            F3_XOR:     alu_sel = ALU_XOR;
            F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_sel = ALU_OR;
            default:    alu_sel = ALU_AND;
        endcase
    endfunction

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign funct7_b5 = i_inst[30];
    assign o_rs1     = i_inst[19:15];
    assign o_rs2     = i_inst[24:20];
    assign o_rd      = i_inst[11:7];

    // I, S and U immediate formats
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_u = {i_inst[31:12], 12'd0};

    always_comb begin
        // Anything not matched below is a no-op that still retires
        write_rd    = 1'b0;
        read_rs1    = 1'b0;
        read_rs2    = 1'b0;
        o_imm_src   = 1'b0;
        o_is_lui    = 1'b0;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_halt      = 1'b0;
        o_imm       = imm_i;
        o_alu_op    = ALU_ADD;
        case (opcode)
            OPC_OP: begin
                write_rd = 1'b1;
                read_rs1 = 1'b1;
                read_rs2 = 1'b1;
                o_alu_op = alu_sel(funct3, funct7_b5);
            end
            OPC_OP_IMM: begin
                write_rd  = 1'b1;
                read_rs1  = 1'b1;
                o_imm_src = 1'b1;
                // Bit 30 is immediate data here except on the right shifts
                o_alu_op  = alu_sel(funct3, (funct3 == F3_SRL_SRA) && funct7_b5);
            end
            OPC_LUI: begin
                write_rd  = 1'b1;
                o_imm_src = 1'b1;
                o_is_lui  = 1'b1;
                o_imm     = imm_u;
            end
            OPC_LOAD: begin
                // Only lw, address is rs1 + imm
                if (funct3 == F3_WORD) begin
                    write_rd   = 1'b1;
                    read_rs1   = 1'b1;
                    o_imm_src  = 1'b1;
                    o_mem_read = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == F3_WORD) begin
                    read_rs1    = 1'b1;
                    read_rs2    = 1'b1;
                    o_imm_src   = 1'b1;
                    o_mem_write = 1'b1;
                    o_imm       = imm_s;
                end
            end
            OPC_SYSTEM: o_halt = (i_inst == INST_EBREAK);
            default: ;
        endcase
    end

    // x0 is neither a real source nor a real destination
    assign o_reg_write = write_rd && (o_rd != '0);
    assign o_uses_rs1  = read_rs1 && (o_rs1 != '0);
    assign o_uses_rs2  = read_rs2 && (o_rs2 != '0);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_rs1_raddr,
    input  reg_addr_t i_rs2_raddr,
    input  reg_addr_t i_rd_waddr,
    input  logic      i_rd_wen,
    input  word_t     i_rd_wdata,
    output word_t     o_rs1_rdata,
    output word_t     o_rs2_rdata
);

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    // Zero for x0, same-cycle write data passes straight through
    function automatic word_t read_port(input reg_addr_t raddr);
        if (raddr == '0)
            read_port = '0;
        else if (i_rd_wen && (i_rd_waddr == raddr))
            read_port = i_rd_wdata;
        else
            read_port = regs[raddr];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            regs[i_rd_waddr] <= i_rd_wdata;
        end
    end

    always_comb begin
        o_rs1_rdata = read_port(i_rs1_raddr);
        o_rs2_rdata = read_port(i_rs2_raddr);
    end

    // The decoder drops writes to x0 before they enter the pipeline
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_wen |-> (i_rd_waddr != '0));

endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

    localparam int    PROG_LEN     = 200;
    localparam int    DATA_WORDS   = 64;
    localparam word_t DATA_BASE    = 32'h0000_0100;
    localparam word_t SEED         = 32'h55a4;
    localparam int    RUN_TIMEOUT  = 4000;
    localparam int    QUIET_CYCLES = 20;

    logic       i_clk = 1'b0;
    logic       i_rst;
    word_t      i_imem_rdata, i_dmem_rdata;
    word_t      o_imem_raddr, o_dmem_addr, o_dmem_wdata;
    logic       o_dmem_ren, o_dmem_wen, o_retire_valid, o_retire_halt;
    logic [3:0] o_dmem_mask;
    word_t      o_retire_inst, o_retire_pc, o_retire_rd_wdata;
    reg_addr_t  o_retire_rd_waddr;

    // Behavioral memories and the LFSR state
    word_t imem [0:PROG_LEN];
    word_t dmem [0:DATA_WORDS-1];
    word_t lfsr = SEED;
    // Expected retire and store streams from the model
    word_t     exp_pc[$], exp_inst[$], exp_data[$], st_addr[$], st_data[$];
    reg_addr_t exp_rd[$];
    int    ret_idx = 0, st_idx = 0, value_errors = 0, other_errors = 0, cycles;
    logic  after_reset = 1'b0;
    word_t mem_iaddr, mem_daddr, mem_wdata;
    logic  mem_ren, mem_wen;

    core_top #(.RESET_ADDR(32'h0)) DUT (.*);

    always #50 i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////////////////////
    // Random source and instruction-set model
    ////////////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic word_t next_lfsr(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t take_bits(input int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = next_lfsr(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Op order: add sub and or xor slt sltu sll srl sra
    function automatic logic [2:0] op_f3(input int op);
        case (op)
            0, 1:    return 3'b000;
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b010;
            6:       return 3'b011;
            7:       return 3'b001;
            default: return 3'b101;
        endcase
    endfunction

    function automatic logic [6:0] op_f7(input int op);
        return (op == 1 || op == 9) ? 7'b0100000 : 7'b0000000;
    endfunction

    function automatic word_t alu_model(input int op, input word_t a, input word_t b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a & b;
            3:       return a | b;
            4:       return a ^ b;
            5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            6:       return (a < b) ? 32'd1 : 32'd0;
            7:       return a << b[4:0];
            8:       return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // Generate one instruction at a time and execute it right away
    task automatic build_program();
        word_t      regs [0:31];
        word_t      dm [0:DATA_WORDS-1];
        word_t      inst, res, addr;
        reg_addr_t  rd, rs1, rs2;
        logic [2:0] kind;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [5:0] idx;
        logic       wr;
        int         op;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DATA_WORDS; i++) begin
            dm[i]   = '0;
            dmem[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind  = take_bits(3);
            rd    = take_bits(3);
            rs1   = take_bits(3);
            rs2   = take_bits(3);
            op    = take_bits(4) % 10;
            imm   = take_bits(12);
            idx   = take_bits(6);
            addr  = DATA_BASE + {idx, 2'b00};
            wr    = 1'b1;
            case (kind)
                3'd0, 3'd1, 3'd2: begin
                    inst = {op_f7(op), rs2, rs1, op_f3(op), rd, OPC_OP};
                    res  = alu_model(op, regs[rs1], regs[rs2]);
                end
                3'd3, 3'd4: begin
                    // There is no subi, and shifts carry funct7 above shamt
                    if (op == 1)
                        op = 0;
                    if (op >= 7)
                        imm = {op_f7(op), imm[4:0]};
                    inst = {imm, rs1, op_f3(op), rd, OPC_OP_IMM};
                    res  = alu_model(op, regs[rs1], {{20{imm[11]}}, imm});
                end
                3'd5: begin
                    upper = take_bits(20);
                    inst  = {upper, rd, OPC_LUI};
                    res   = {upper, 12'd0};
                end
                3'd6: begin
                    inst = {addr[11:0], 5'd0, F3_WORD, rd, OPC_LOAD};
                    res  = dm[idx];
                end
                default: begin
                    inst    = {addr[11:5], rs2, 5'd0, F3_WORD, addr[4:0], OPC_STORE};
                    res     = '0;
                    wr      = 1'b0;
                    dm[idx] = regs[rs2];
                    st_addr.push_back(addr);
                    st_data.push_back(regs[rs2]);
                end
            endcase
            if (!wr || rd == 0)
                rd = '0;
            else
                regs[rd] = res;
            imem[i] = inst;
            exp_pc.push_back(i * 4);
            exp_inst.push_back(inst);
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
        imem[PROG_LEN] = INST_EBREAK;
        exp_pc.push_back(PROG_LEN * 4);
        exp_inst.push_back(INST_EBREAK);
        exp_rd.push_back('0);
        exp_data.push_back('0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: expected x%0d, actual x%0d", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_retire();
        string tag;
        tag = $sformatf("retire %0d", ret_idx);
        if (ret_idx >= exp_pc.size()) begin
            other_errors++;
            $display("Instruction at pc %h retired after the halt", o_retire_pc);
        end else begin
            compare_word({tag, " pc"}, exp_pc[ret_idx], o_retire_pc);
            compare_word({tag, " inst"}, exp_inst[ret_idx], o_retire_inst);
            compare_reg({tag, " rd"}, exp_rd[ret_idx], o_retire_rd_waddr);
            // Data only means something when a register is written
            if (exp_rd[ret_idx] != 0)
                compare_word({tag, " data"}, exp_data[ret_idx], o_retire_rd_wdata);
            compare_bit({tag, " halt"}, ret_idx == exp_pc.size() - 1, o_retire_halt);
        end
        ret_idx++;
    endtask

    task automatic check_store();
        string tag;
        tag = $sformatf("store %0d", st_idx);
        if (st_idx >= st_addr.size()) begin
            other_errors++;
            $display("Unexpected store to %h", o_dmem_addr);
        end else begin
            compare_word({tag, " addr"}, st_addr[st_idx], o_dmem_addr);
            compare_word({tag, " data"}, st_data[st_idx], o_dmem_wdata);
            compare_word({tag, " mask"}, 32'hf, word_t'(o_dmem_mask));
        end
        st_idx++;
    endtask

    // Mid-cycle monitor, all DUT outputs are settled here
    always @(negedge i_clk) begin
        if (i_rst || after_reset) begin
            compare_bit("reset retire_valid", 1'b0, o_retire_valid);
            compare_bit("reset dmem_wen", 1'b0, o_dmem_wen);
            compare_bit("reset dmem_ren", 1'b0, o_dmem_ren);
        end
        after_reset = i_rst;
        if (!i_rst && o_retire_valid)
            check_retire();
        if (!i_rst && o_dmem_wen)
            check_store();
    end

    // Both memories sample on the edge and answer 1 ns later
    always @(posedge i_clk) begin
        mem_iaddr = o_imem_raddr;
        mem_daddr = o_dmem_addr - DATA_BASE;
        mem_ren   = o_dmem_ren;
        mem_wen   = o_dmem_wen;
        mem_wdata = o_dmem_wdata;
        if (!i_rst && (mem_ren || mem_wen) && mem_daddr >= DATA_WORDS * 4) begin
            other_errors++;
            $display("Data access at %h is outside the data region", o_dmem_addr);
        end else if (!i_rst && mem_wen) begin
            dmem[mem_daddr[7:2]] = mem_wdata;
        end
        #1;
        // Past the program the bus echoes the address
        i_imem_rdata = (mem_iaddr[31:2] <= PROG_LEN) ? imem[mem_iaddr[31:2]] : mem_iaddr;
        if (!i_rst && mem_ren)
            i_dmem_rdata = dmem[mem_daddr[7:2]];
    end

    initial begin
        i_rst        = 1'b1;
        i_imem_rdata = NOP_INST;
        i_dmem_rdata = '0;
        build_program();
        repeat (10) @(posedge i_clk);
        #1 i_rst = 1'b0;
        cycles = 0;
        while (ret_idx < exp_pc.size() && cycles < RUN_TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (ret_idx < exp_pc.size()) begin
            other_errors++;
            $display("Timeout: only %0d of %0d instructions retired", ret_idx, exp_pc.size());
        end
        // Nothing may retire once the halt is out
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge i_clk);
            cycles++;
        end
        if (st_idx != st_addr.size()) begin
            other_errors++;
            $display("Saw %0d stores but the program makes %0d", st_idx, st_addr.size());
        end
        $display("Value mismatches: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
